//--- hw/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_SRC    = 2;
    localparam int OP_W       = 4;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

    // branch compares, funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // op field for the U and J classes
    localparam logic [OP_W-1:0] OP_LUI   = 4'd0;
    localparam logic [OP_W-1:0] OP_AUIPC = 4'd1;
    localparam logic [OP_W-1:0] OP_JAL   = 4'd0;
    localparam logic [OP_W-1:0] OP_JALR  = 4'd1;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_R,
        CLS_I,
        CLS_U,
        CLS_L,
        CLS_S,
        CLS_J,
        CLS_B
    } inst_class_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND
    } alu_op_e;

endpackage

//--- hw/inst_decoder.sv
module inst_decoder
    import rv_decode_pkg::*;
(
    input  logic                                inst_valid_i,
    input  logic [INST_W-1:0]                   inst_i,
    output inst_class_e                         class_o,
    output logic [OP_W-1:0]                     op_o,
    output logic [NUM_SRC-1:0][REG_ADDR_W-1:0]  rs_addr_o,
    output logic [NUM_SRC-1:0]                  rs_re_o,
    output logic [REG_ADDR_W-1:0]               rd_addr_o,
    output logic                                rd_we_o,
    output logic [XLEN-1:0]                     imm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_free;    // funct7 is immediate bits here
    logic       f7_ok;

    alu_op_e         alu_op;
    logic            alu_ok;
    inst_class_e     cls;
    logic [OP_W-1:0] op;
    logic            is_jalr;

    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_s_type;
    logic [XLEN-1:0] imm_b_type;
    logic [XLEN-1:0] imm_j_type;
    logic [XLEN-1:0] imm_u_type;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign f7_free = (opcode == OPC_OP_IMM);
    assign f7_ok   = f7_free || (funct7 == F7_BASE);

    assign imm_i_type = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{(XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_type = {{(XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_type = {{(XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u_type = {inst_i[31:12], {(XLEN-20){1'b0}}};

    // alu op shared by R and I arithmetic
    always_comb begin
        alu_op = ADD;
        alu_ok = 1'b0;
        case (funct3)
            3'b000: begin
                if (f7_ok) begin
                    alu_ok = 1'b1;
                end else if (funct7 == F7_ALT) begin
                    alu_op = SUB;
                    alu_ok = 1'b1;
                end
            end
            3'b001: begin
                alu_op = SLL;
                alu_ok = (funct7 == F7_BASE);   // slli too
            end
            3'b010: begin
                alu_op = SLT;
                alu_ok = f7_ok;
            end
            3'b011: begin
                alu_op = SLTU;
                alu_ok = f7_ok;
            end
            3'b100: begin
                alu_op = XOR;
                alu_ok = f7_ok;
            end
            3'b101: begin
                alu_op = (funct7 == F7_ALT) ? SRA : SRL;
                alu_ok = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            end
            3'b110: begin
                alu_op = OR;
                alu_ok = f7_ok;
            end
            default: begin
                alu_op = AND;
                alu_ok = f7_ok;
            end
        endcase
    end

    always_comb begin
        cls     = CLS_NONE;
        op      = '0;
        is_jalr = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (alu_ok) begin
                    cls = CLS_R;
                    op  = alu_op;
                end
            end
            OPC_OP_IMM: begin
                if (alu_ok) begin
                    cls = CLS_I;
                    op  = alu_op;
                end
            end
            OPC_LUI: begin
                cls = CLS_U;
                op  = OP_LUI;
            end
            OPC_AUIPC: begin
                cls = CLS_U;
                op  = OP_AUIPC;
            end
            OPC_LOAD: begin
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin  // lb lh lw lbu lhu
                    cls = CLS_L;
                    op  = {1'b0, funct3};
                end
            end
            OPC_STORE: begin
                if (funct3 <= 3'b010) begin
                    cls = CLS_S;
                    op  = {1'b0, funct3};
                end
            end
            OPC_JAL: begin
                cls = CLS_J;
                op  = OP_JAL;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    cls     = CLS_J;
                    op      = OP_JALR;
                    is_jalr = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin
                    cls = CLS_B;
                    op  = {1'b0, funct3};
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        class_o   = CLS_NONE;
        op_o      = '0;
        rs_addr_o = '0;
        rs_re_o   = '0;
        rd_addr_o = '0;
        rd_we_o   = 1'b0;
        imm_o     = '0;
        if (inst_valid_i) begin
            class_o      = cls;
            op_o         = op;
            rs_addr_o[0] = inst_i[19:15];
            rs_addr_o[1] = inst_i[24:20];
            rs_re_o[0]   = (cls inside {CLS_R, CLS_I, CLS_L, CLS_S, CLS_B}) || is_jalr;
            rs_re_o[1]   = cls inside {CLS_R, CLS_S, CLS_B};
            rd_we_o      = cls inside {CLS_R, CLS_I, CLS_U, CLS_J};
            rd_addr_o    = (cls inside {CLS_S, CLS_B}) ? '0 : inst_i[11:7];
            case (cls)
                CLS_I, CLS_L: imm_o = imm_i_type;
                CLS_S:        imm_o = imm_s_type;
                CLS_B:        imm_o = imm_b_type;
                CLS_U:        imm_o = imm_u_type;
                CLS_J:        imm_o = is_jalr ? imm_i_type : imm_j_type;
                default:      imm_o = '0;
            endcase
        end
    end

endmodule

//--- hw/operand_forward.sv
module operand_forward
    import rv_decode_pkg::*;
(
    input  logic [REG_ADDR_W-1:0] src_addr_i,
    input  logic                  src_re_i,
    input  logic [XLEN-1:0]       rf_data_i,
    input  logic                  ex_rd_we_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input  logic [XLEN-1:0]       ex_rd_data_i,
    input  logic                  ex_load_i,
    input  logic                  ls_rd_we_i,
    input  logic [REG_ADDR_W-1:0] ls_rd_addr_i,
    input  logic [XLEN-1:0]       ls_rd_data_i,
    output logic [XLEN-1:0]       src_data_o,
    output logic                  hazard_o
);

    logic src_zero;
    logic ex_match;
    logic ex_hit;
    logic ls_hit;

    assign src_zero = (src_addr_i == '0);
    assign ex_match = (src_addr_i == ex_rd_addr_i);
    assign ex_hit   = ex_rd_we_i && ex_match;
    assign ls_hit   = ls_rd_we_i && (src_addr_i == ls_rd_addr_i);

    always_comb begin
        if (src_zero)      src_data_o = rf_data_i;      // x0 never forwarded
        else if (ex_hit)   src_data_o = ex_rd_data_i;   // youngest result first
        else if (ls_hit)   src_data_o = ls_rd_data_i;
        else               src_data_o = rf_data_i;
    end

    // load in execute has no data yet
    assign hazard_o = src_re_i && !src_zero && ex_match && ex_load_i;

endmodule

//--- hw/branch_unit.sv
module branch_unit
    import rv_decode_pkg::*;
(
    input  inst_class_e     class_i,
    input  logic [OP_W-1:0] op_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic            stall_i,
    output logic            jump_req_o,
    output logic [XLEN-1:0] jump_pc_o
);

    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            taken;
    logic            jump;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] reg_sum;

    assign is_branch = (class_i == CLS_B);
    assign is_jal    = (class_i == CLS_J) && (op_i == OP_JAL);
    assign is_jalr   = (class_i == CLS_J) && (op_i == OP_JALR);

    always_comb begin
        case (op_i)
            {1'b0, F3_BEQ}:  taken = (rs1_data_i == rs2_data_i);
            {1'b0, F3_BNE}:  taken = (rs1_data_i != rs2_data_i);
            {1'b0, F3_BLT}:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            {1'b0, F3_BGE}:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            {1'b0, F3_BLTU}: taken = (rs1_data_i < rs2_data_i);
            {1'b0, F3_BGEU}: taken = (rs1_data_i >= rs2_data_i);
            default:         taken = 1'b0;
        endcase
    end

    assign pc_target = pc_i + imm_i;    // jal and branches
    assign reg_sum   = rs1_data_i + imm_i;

    assign jump       = (is_branch && taken) || is_jal || is_jalr;
    assign jump_req_o = jump && !stall_i;   // operands not ready yet

    always_comb begin
        if (!jump_req_o) jump_pc_o = '0;
        else if (is_jalr) jump_pc_o = {reg_sum[XLEN-1:1], 1'b0};
        else              jump_pc_o = pc_target;
    end

endmodule

//--- hw/issue_reg.sv
module issue_reg
    import rv_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  logic                  stall_i,
    input  logic [XLEN-1:0]       pc_i,
    input  inst_class_e           class_i,
    input  logic [OP_W-1:0]       op_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  rd_we_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic                  iss_valid_o,
    output logic [XLEN-1:0]       iss_pc_o,
    output inst_class_e           iss_class_o,
    output logic [OP_W-1:0]       iss_op_o,
    output logic [REG_ADDR_W-1:0] iss_rd_addr_o,
    output logic                  iss_rd_we_o,
    output logic [XLEN-1:0]       iss_op1_o,
    output logic [XLEN-1:0]       iss_op2_o,
    output logic [XLEN-1:0]       iss_imm_o
);

    logic            issue;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;

    assign issue = inst_valid_i && !stall_i;
    assign op1   = (class_i inside {CLS_R, CLS_I, CLS_L, CLS_S}) ? rs1_data_i : '0;
    assign op2   = (class_i inside {CLS_R, CLS_S}) ? rs2_data_i : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iss_valid_o   <= 1'b0;
            iss_class_o   <= CLS_NONE;
            iss_op_o      <= '0;
            iss_rd_addr_o <= '0;
            iss_rd_we_o   <= 1'b0;
        end else if (issue) begin
            iss_valid_o   <= 1'b1;
            iss_class_o   <= class_i;
            iss_op_o      <= op_i;
            iss_rd_addr_o <= rd_addr_i;
            iss_rd_we_o   <= rd_we_i;
        end else begin      // bubble
            iss_valid_o   <= 1'b0;
            iss_class_o   <= CLS_NONE;
            iss_op_o      <= '0;
            iss_rd_addr_o <= '0;
            iss_rd_we_o   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        iss_pc_o  <= pc_i;
        iss_op1_o <= op1;
        iss_op2_o <= op2;
        iss_imm_o <= imm_i;
    end

endmodule

//--- hw/decode_stage.sv
module decode_stage
    import rv_decode_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n_i,
    // fetch
    input  logic                                inst_valid_i,
    input  logic [XLEN-1:0]                     pc_i,
    input  logic [INST_W-1:0]                   inst_i,
    // register file
    output logic [NUM_SRC-1:0][REG_ADDR_W-1:0]  rs_addr_o,
    input  logic [NUM_SRC-1:0][XLEN-1:0]        rs_data_i,
    // execute
    input  logic                                ex_rd_we_i,
    input  logic [REG_ADDR_W-1:0]               ex_rd_addr_i,
    input  logic [XLEN-1:0]                     ex_rd_data_i,
    input  logic                                ex_load_i,
    // load/store
    input  logic                                ls_rd_we_i,
    input  logic [REG_ADDR_W-1:0]               ls_rd_addr_i,
    input  logic [XLEN-1:0]                     ls_rd_data_i,
    // back to fetch
    output logic                                stall_req_o,
    output logic                                jump_req_o,
    output logic [XLEN-1:0]                     jump_pc_o,
    // issue to execute
    output logic                                iss_valid_o,
    output logic [XLEN-1:0]                     iss_pc_o,
    output inst_class_e                         iss_class_o,
    output logic [OP_W-1:0]                     iss_op_o,
    output logic [REG_ADDR_W-1:0]               iss_rd_addr_o,
    output logic                                iss_rd_we_o,
    output logic [XLEN-1:0]                     iss_op1_o,
    output logic [XLEN-1:0]                     iss_op2_o,
    output logic [XLEN-1:0]                     iss_imm_o
);

    inst_class_e                         dec_class;
    logic [OP_W-1:0]                     dec_op;
    logic [NUM_SRC-1:0][REG_ADDR_W-1:0]  rs_addr;
    logic [NUM_SRC-1:0]                  rs_re;
    logic [REG_ADDR_W-1:0]               dec_rd_addr;
    logic                                dec_rd_we;
    logic [XLEN-1:0]                     dec_imm;
    logic [NUM_SRC-1:0][XLEN-1:0]        fwd_data;
    logic [NUM_SRC-1:0]                  hazard;

    inst_decoder u_dec (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .class_o      (dec_class),
        .op_o         (dec_op),
        .rs_addr_o    (rs_addr),
        .rs_re_o      (rs_re),
        .rd_addr_o    (dec_rd_addr),
        .rd_we_o      (dec_rd_we),
        .imm_o        (dec_imm)
    );

    assign rs_addr_o = rs_addr;

    for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
        operand_forward u_fwd (
            .src_addr_i   (rs_addr[i]),
            .src_re_i     (rs_re[i]),
            .rf_data_i    (rs_data_i[i]),
            .ex_rd_we_i   (ex_rd_we_i),
            .ex_rd_addr_i (ex_rd_addr_i),
            .ex_rd_data_i (ex_rd_data_i),
            .ex_load_i    (ex_load_i),
            .ls_rd_we_i   (ls_rd_we_i),
            .ls_rd_addr_i (ls_rd_addr_i),
            .ls_rd_data_i (ls_rd_data_i),
            .src_data_o   (fwd_data[i]),
            .hazard_o     (hazard[i])
        );
    end

    assign stall_req_o = |hazard;   // either source waits on a load

    branch_unit u_br (
        .class_i    (dec_class),
        .op_i       (dec_op),
        .pc_i       (pc_i),
        .imm_i      (dec_imm),
        .rs1_data_i (fwd_data[0]),
        .rs2_data_i (fwd_data[1]),
        .stall_i    (stall_req_o),
        .jump_req_o (jump_req_o),
        .jump_pc_o  (jump_pc_o)
    );

    issue_reg u_iss (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .stall_i       (stall_req_o),
        .pc_i          (pc_i),
        .class_i       (dec_class),
        .op_i          (dec_op),
        .rd_addr_i     (dec_rd_addr),
        .rd_we_i       (dec_rd_we),
        .imm_i         (dec_imm),
        .rs1_data_i    (fwd_data[0]),
        .rs2_data_i    (fwd_data[1]),
        .iss_valid_o   (iss_valid_o),
        .iss_pc_o      (iss_pc_o),
        .iss_class_o   (iss_class_o),
        .iss_op_o      (iss_op_o),
        .iss_rd_addr_o (iss_rd_addr_o),
        .iss_rd_we_o   (iss_rd_we_o),
        .iss_op1_o     (iss_op1_o),
        .iss_op2_o     (iss_op2_o),
        .iss_imm_o     (iss_imm_o)
    );

endmodule

//--- tb/decode_stage_asserts.sv
module decode_stage_asserts (
    input logic clk,
    input logic rst_n_i,
    input logic stall_req_i,
    input logic jump_req_i,
    input logic iss_valid_i,
    input logic iss_rd_we_i
);

    int fail_count = 0;

    a_no_jump_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(jump_req_i && stall_req_i))
        else begin
            $error("jump request raised while a stall is requested");
            fail_count++;
        end

    // stalled instruction becomes a bubble
    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_req_i |=> !iss_valid_i)
        else begin
            $error("issue register valid after a stall cycle");
            fail_count++;
        end

    a_we_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        iss_rd_we_i |-> iss_valid_i)
        else begin
            $error("iss_rd_we_o high without iss_valid_o");
            fail_count++;
        end

endmodule

//--- tb/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

function automatic logic [3:0] alu_op_for(input logic [2:0] f3, input logic alt);
    alu_op_e a;
    case (f3)
        3'd0:    a = alt ? SUB : ADD;
        3'd1:    a = SLL;
        3'd2:    a = SLT;
        3'd3:    a = SLTU;
        3'd4:    a = XOR;
        3'd5:    a = alt ? SRA : SRL;
        3'd6:    a = OR;
        default: a = AND;
    endcase
    return a;
endfunction

// expected decoder fields for one instruction word
function automatic void expected_decode(
    input  logic        valid,
    input  logic [31:0] ins,
    output inst_class_e cls,
    output logic [3:0]  op,
    output logic        re1,
    output logic        re2,
    output logic [4:0]  rd,
    output logic        we,
    output logic [31:0] imm
);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;
    f3  = ins[14:12];
    f7  = ins[31:25];
    alt = (f7 == 7'h20);
    cls = CLS_NONE;
    op  = 4'd0;
    if (valid) begin
        case (ins[6:0])
            OPC_OP: begin
                if (f7 == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5))) begin
                    cls = CLS_R;
                    op  = alu_op_for(f3, alt);
                end
            end
            OPC_OP_IMM: begin
                // funct7 only matters for the shifts
                if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && alt)) begin
                    cls = CLS_I;
                    op  = alu_op_for(f3, alt && f3 == 3'd5);
                end
            end
            OPC_LUI:   cls = CLS_U;
            OPC_AUIPC: begin
                cls = CLS_U;
                op  = 4'd1;
            end
            OPC_LOAD:   if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) cls = CLS_L;
            OPC_STORE:  if (f3 inside {3'd0, 3'd1, 3'd2}) cls = CLS_S;
            OPC_JAL:    cls = CLS_J;
            OPC_JALR: begin
                if (f3 == 3'd0) begin
                    cls = CLS_J;
                    op  = 4'd1;
                end
            end
            OPC_BRANCH: if (f3 != 3'd2 && f3 != 3'd3) cls = CLS_B;
            default: cls = CLS_NONE;
        endcase
        if (cls inside {CLS_L, CLS_S, CLS_B}) op = {1'b0, f3};
    end
    re1 = (cls inside {CLS_R, CLS_I, CLS_L, CLS_S, CLS_B}) || (cls == CLS_J && op == 4'd1);
    re2 = cls inside {CLS_R, CLS_S, CLS_B};
    we  = cls inside {CLS_R, CLS_I, CLS_U, CLS_J};
    rd  = (!valid || cls inside {CLS_S, CLS_B}) ? 5'd0 : ins[11:7];
    case (cls)
        CLS_I, CLS_L: imm = {{20{ins[31]}}, ins[31:20]};
        CLS_S:        imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        CLS_B:        imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        CLS_U:        imm = {ins[31:12], 12'h000};
        CLS_J:        imm = (op == 4'd1) ? {{20{ins[31]}}, ins[31:20]}
                                         : {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        default:      imm = 32'd0;
    endcase
endfunction

function automatic logic [31:0] forwarded_value(
    input logic [4:0] addr, input logic [31:0] rf,
    input logic ex_we, input logic [4:0] ex_addr, input logic [31:0] ex_data,
    input logic ls_we, input logic [4:0] ls_addr, input logic [31:0] ls_data
);
    if (addr == 5'd0) return rf;
    if (ex_we && addr == ex_addr) return ex_data;
    if (ls_we && addr == ls_addr) return ls_data;
    return rf;
endfunction

function automatic logic branch_taken(
    input logic [2:0]  f3,
    input logic [31:0] a,
    input logic [31:0] b
);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

`endif

//--- tb/tb_decode_stage.sv
module tb_decode_stage
    import rv_decode_pkg::*;
();

    localparam logic [31:0] SEED           = 32'h4931;
    localparam int          N_TESTS        = 2000;
    localparam int          TIMEOUT_CYCLES = 3 * N_TESTS + 40;

    logic                               clk;
    logic                               rst_n_i;
    logic                               inst_valid_i;
    logic [XLEN-1:0]                    pc_i;
    logic [INST_W-1:0]                  inst_i;
    logic [NUM_SRC-1:0][REG_ADDR_W-1:0] rs_addr_o;
    logic [NUM_SRC-1:0][XLEN-1:0]       rs_data_i;
    logic                               ex_rd_we_i;
    logic [REG_ADDR_W-1:0]              ex_rd_addr_i;
    logic [XLEN-1:0]                    ex_rd_data_i;
    logic                               ex_load_i;
    logic                               ls_rd_we_i;
    logic [REG_ADDR_W-1:0]              ls_rd_addr_i;
    logic [XLEN-1:0]                    ls_rd_data_i;
    logic                               stall_req_o;
    logic                               jump_req_o;
    logic [XLEN-1:0]                    jump_pc_o;
    logic                               iss_valid_o;
    logic [XLEN-1:0]                    iss_pc_o;
    inst_class_e                        iss_class_o;
    logic [OP_W-1:0]                    iss_op_o;
    logic [REG_ADDR_W-1:0]              iss_rd_addr_o;
    logic                               iss_rd_we_o;
    logic [XLEN-1:0]                    iss_op1_o;
    logic [XLEN-1:0]                    iss_op2_o;
    logic [XLEN-1:0]                    iss_imm_o;

    logic [31:0] lfsr;
    int          cycle_count = 0;

    // issue values expected one edge after the current instruction
    logic        exp_valid;
    inst_class_e exp_class;
    logic [3:0]  exp_op;
    logic [4:0]  exp_rd;
    logic        exp_we;
    logic [31:0] exp_pc;
    logic [31:0] exp_op1;
    logic [31:0] exp_op2;
    logic [31:0] exp_imm;

    `include "decode_ref_model.svh"

    decode_stage uut (.*);

    bind decode_stage decode_stage_asserts u_asserts (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_req_i (stall_req_o),
        .jump_req_i  (jump_req_o),
        .iss_valid_i (iss_valid_o),
        .iss_rd_we_i (iss_rd_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_random();
        logic [3:0]  kind;
        logic [6:0]  hi;
        logic [6:0]  opc;
        logic [3:0]  up;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] d0;
        kind = 4'(rand_bits(4));
        hi   = 7'(rand_bits(7));
        case (kind)
            4'd0, 4'd1: opc = OPC_OP;
            4'd2, 4'd3: opc = OPC_OP_IMM;
            4'd4:       opc = OPC_LUI;
            4'd5:       opc = OPC_AUIPC;
            4'd6, 4'd7: opc = OPC_LOAD;
            4'd8:       opc = OPC_STORE;
            4'd9:       opc = OPC_JAL;
            4'd10:      opc = OPC_JALR;
            4'd14, 4'd15: opc = 7'(rand_bits(7));   // mostly illegal
            default:    opc = OPC_BRANCH;
        endcase
        if (kind < 4'd4 && hi[6:5] != 2'b11) hi = hi[4] ? 7'h20 : 7'h00;
        up  = (opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL}) ? 4'(rand_bits(4)) : 4'd0;
        rs1 = 3'(rand_bits(3));
        rs2 = 3'(rand_bits(3));
        f3  = 3'(rand_bits(3));
        rd  = 5'(rand_bits(5));
        inst_i       <= {hi, up[3:2], rs2, up[1:0], rs1, f3, rd, opc};
        inst_valid_i <= (rand_bits(3) != 0);
        pc_i         <= rand_bits(32);
        d0 = rand_bits(32);
        rs_data_i[0] <= d0;
        rs_data_i[1] <= (rand_bits(2) == 0) ? d0 : rand_bits(32);  // equal operands now and then
        ex_rd_we_i   <= rand_bits(1) != 0;
        ex_rd_addr_i <= 5'(rand_bits(3));
        ex_rd_data_i <= rand_bits(32);
        ex_load_i    <= (rand_bits(2) == 0);
        ls_rd_we_i   <= rand_bits(1) != 0;
        ls_rd_addr_i <= 5'(rand_bits(3));
        ls_rd_data_i <= rand_bits(32);
    endtask

    task automatic verify_cycle();
        inst_class_e cls;
        logic [3:0]  op;
        logic        re1;
        logic        re2;
        logic        we;
        logic        stall;
        logic        jump;
        logic [4:0]  rd;
        logic [4:0]  a1;
        logic [4:0]  a2;
        logic [31:0] imm;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] target;
        expect_equal("iss_valid", 32'(exp_valid), 32'(iss_valid_o));
        expect_equal("iss_class", 32'(exp_class), 32'(iss_class_o));
        expect_equal("iss_op", 32'(exp_op), 32'(iss_op_o));
        expect_equal("iss_rd_addr", 32'(exp_rd), 32'(iss_rd_addr_o));
        expect_equal("iss_rd_we", 32'(exp_we), 32'(iss_rd_we_o));
        if (exp_valid) begin    // data fields are don't care in a bubble
            expect_equal("iss_pc", exp_pc, iss_pc_o);
            expect_equal("iss_op1", exp_op1, iss_op1_o);
            expect_equal("iss_op2", exp_op2, iss_op2_o);
            expect_equal("iss_imm", exp_imm, iss_imm_o);
        end
        expected_decode(inst_valid_i, inst_i, cls, op, re1, re2, rd, we, imm);
        a1 = inst_valid_i ? inst_i[19:15] : 5'd0;
        a2 = inst_valid_i ? inst_i[24:20] : 5'd0;
        d1 = forwarded_value(a1, rs_data_i[0], ex_rd_we_i, ex_rd_addr_i, ex_rd_data_i,
                             ls_rd_we_i, ls_rd_addr_i, ls_rd_data_i);
        d2 = forwarded_value(a2, rs_data_i[1], ex_rd_we_i, ex_rd_addr_i, ex_rd_data_i,
                             ls_rd_we_i, ls_rd_addr_i, ls_rd_data_i);
        stall = ex_load_i && ((re1 && a1 != 5'd0 && a1 == ex_rd_addr_i) ||
                              (re2 && a2 != 5'd0 && a2 == ex_rd_addr_i));
        jump   = 1'b0;
        target = 32'd0;
        if (!stall && cls == CLS_B && branch_taken(op[2:0], d1, d2)) begin
            jump   = 1'b1;
            target = pc_i + imm;
        end else if (!stall && cls == CLS_J) begin
            jump   = 1'b1;
            target = (op == 4'd1) ? ((d1 + imm) & ~32'd1) : (pc_i + imm);
        end
        expect_equal("rs1_addr", 32'(a1), 32'(rs_addr_o[0]));
        expect_equal("rs2_addr", 32'(a2), 32'(rs_addr_o[1]));
        expect_equal("stall_req", 32'(stall), 32'(stall_req_o));
        expect_equal("jump_req", 32'(jump), 32'(jump_req_o));
        expect_equal("jump_pc", target, jump_pc_o);
        exp_valid = inst_valid_i && !stall;
        exp_class = exp_valid ? cls : CLS_NONE;
        exp_op    = exp_valid ? op : 4'd0;
        exp_rd    = exp_valid ? rd : 5'd0;
        exp_we    = exp_valid && we;
        exp_pc    = pc_i;
        exp_imm   = imm;
        exp_op1   = (cls inside {CLS_R, CLS_I, CLS_L, CLS_S}) ? d1 : 32'd0;
        exp_op2   = (cls inside {CLS_R, CLS_S}) ? d2 : 32'd0;
    endtask

    initial begin
        lfsr         = SEED;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        rs_data_i    = '0;
        ex_rd_we_i   = 1'b0;
        ex_rd_addr_i = '0;
        ex_rd_data_i = '0;
        ex_load_i    = 1'b0;
        ls_rd_we_i   = 1'b0;
        ls_rd_addr_i = '0;
        ls_rd_data_i = '0;
        exp_valid    = 1'b0;
        exp_class    = CLS_NONE;
        exp_op       = '0;
        exp_rd       = '0;
        exp_we       = 1'b0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        expect_equal("reset iss_valid", 32'(1'b0), 32'(iss_valid_o));
        expect_equal("reset iss_rd_we", 32'(1'b0), 32'(iss_rd_we_o));
        expect_equal("reset iss_class", 32'(CLS_NONE), 32'(iss_class_o));
        @(posedge clk);
        rst_n_i <= 1'b1;
        for (int n = 0; n < N_TESTS; n++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            verify_cycle();
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;
        @(negedge clk);
        verify_cycle();     // drains the last issued instruction
        if (uut.u_asserts.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("%0d assertion failures in the bound checks", uut.u_asserts.fail_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- sources.f
+incdir+tb
hw/rv_decode_pkg.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/branch_unit.sv
hw/issue_reg.sv
hw/decode_stage.sv
tb/decode_stage_asserts.sv
tb/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_decode_stage -f sources.f \
    -o sim_decode > build.log 2>&1 &&
    ./obj_dir/sim_decode > sim.log 2>&1 ||
    { cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || exit 1
